// File: Makefile
# Verilator build and run of the link traffic generator testbench

TOP = tb_noc_perf
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on TB FAILED in $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: compile.f
src/noc_perf_pkg.sv
src/flit_stream_if.sv
src/inject_gate.sv
src/packet_builder.sv
src/flit_queue.sv
src/latency_sink.sv
src/noc_perf_top.sv
test/tb_link_checker.sv
test/tb_noc_perf.sv

// File: src/flit_queue.sv
// Flit FIFO between the packet builder and the outgoing link
// Absorbs link back-pressure; ready to the builder drops when full
`default_nettype none

module flit_queue
  (input  logic                                   link_clk_i,
   input  logic                                   link_reset_i,
   flit_stream_if.sink                            enq,
   output logic                                   link_v_o,
   output logic [noc_perf_pkg::flit_width_lp-1:0] link_data_o,
   input  logic                                   link_ready_and_i);

  import noc_perf_pkg::*;

  flit_u                      data_mem [2 ** lg_queue_depth_lp];
  logic                       last_mem [2 ** lg_queue_depth_lp];
  logic [lg_queue_depth_lp:0] wr_ptr_r;    // Extra top bit marks the wrap
  logic [lg_queue_depth_lp:0] rd_ptr_r;
  logic [lg_queue_depth_lp:0] count;       // Flits held
  logic                       full;
  logic                       empty;
  logic                       wr_en;
  logic                       rd_en;
  flit_u                      head;
  logic                       head_last;
  logic                       after_last_r;

  assign count = wr_ptr_r - rd_ptr_r;
  assign empty = (wr_ptr_r == rd_ptr_r);
  assign full  = (wr_ptr_r[lg_queue_depth_lp] != rd_ptr_r[lg_queue_depth_lp]) &&
                 (wr_ptr_r[lg_queue_depth_lp-1:0] == rd_ptr_r[lg_queue_depth_lp-1:0]);

  assign enq.ready = !full;
  assign wr_en     = enq.valid && enq.ready;
  assign rd_en     = link_v_o && link_ready_and_i;

  // ********************
  // Storage
  // ********************
  always_ff @(posedge link_clk_i)
  begin
    if (wr_en)
    begin
      data_mem[wr_ptr_r[lg_queue_depth_lp-1:0]] <= enq.data;
      last_mem[wr_ptr_r[lg_queue_depth_lp-1:0]] <= enq.last;
    end
  end

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      wr_ptr_r     <= '0;
      rd_ptr_r     <= '0;
      after_last_r <= 1'b1;   // First flit out is a header
    end
    else
    begin
      if (wr_en)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (rd_en)
      begin
        rd_ptr_r     <= rd_ptr_r + 1'b1;
        after_last_r <= head_last;
      end
    end
  end

  assign head        = data_mem[rd_ptr_r[lg_queue_depth_lp-1:0]];
  assign head_last   = last_mem[rd_ptr_r[lg_queue_depth_lp-1:0]];
  assign link_v_o    = !empty;
  assign link_data_o = head;

  // Occupancy stays within the depth, so no overrun and no underrun
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    !count[lg_queue_depth_lp] || (count[lg_queue_depth_lp-1:0] == '0));

  // Flit leaving after a packet end must be a well formed header
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    (rd_en && after_last_r) |-> (head.header.len == 4'(len_lp)));

endmodule

`default_nettype wire

// File: src/flit_stream_if.sv
// Valid/ready flit stream between two pipeline stages
// A flit moves on a rising edge where valid and ready are both high
`default_nettype none

interface flit_stream_if;
  import noc_perf_pkg::*;

  logic  valid;
  logic  ready;
  flit_u data;
  logic  last;   // Final flit of a packet

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: src/inject_gate.sv
// Decides per enabled cycle whether a packet is wanted, using an LFSR draw
// against the utilization threshold, and keeps count of outstanding requests
`default_nettype none

module inject_gate
  #(parameter int utilization_p = 128)  // Hits per 256 enabled cycles
  (input  logic        link_clk_i,
   input  logic        link_reset_i,
   input  logic        link_en_i,
   input  logic        take_i,
   output logic [3:0]  pending_o,
   output logic [15:0] dropped_o);

  import noc_perf_pkg::*;

  logic [15:0] lfsr_r;
  logic [15:0] lfsr_next;
  logic        hit_r;
  logic [3:0]  pending_r;
  logic [15:0] dropped_r;
  logic        at_max;

  assign lfsr_next = lfsr_r[0] ? ((lfsr_r >> 1) ^ lfsr_taps_lp) : (lfsr_r >> 1);
  assign at_max    = (pending_r == 4'(pending_max_lp));

  // ********************
  // Random draw
  // ********************
  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      lfsr_r <= lfsr_seed_lp;
      hit_r  <= 1'b0;
    end
    else if (link_en_i)
    begin
      lfsr_r <= lfsr_next;
      hit_r  <= ({1'b0, lfsr_next[7:0]} < 9'(utilization_p));
    end
    else
      hit_r <= 1'b0;
  end

  // Hit and take together leave the count alone
  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      pending_r <= '0;
      dropped_r <= '0;
    end
    else if (hit_r && !take_i)
    begin
      if (at_max)
        dropped_r <= dropped_r + 16'd1;  // Request lost
      else
        pending_r <= pending_r + 4'd1;
    end
    else if (take_i && !hit_r)
      pending_r <= pending_r - 4'd1;
  end

  assign pending_o = pending_r;
  assign dropped_o = dropped_r;

  // Builder only starts a packet against an outstanding request
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    take_i |-> (pending_r != '0));

endmodule

`default_nettype wire

// File: src/latency_sink.sv
// Receiving end of the link; checks packet framing and measures latency
// from the header timestamp against its own cycle count
`default_nettype none

module latency_sink
  (input  logic                                   link_clk_i,
   input  logic                                   link_reset_i,
   input  logic                                   link_v_i,
   input  logic [noc_perf_pkg::flit_width_lp-1:0] link_data_i,
   output logic                                   link_ready_and_o,
   output logic [15:0]                            rx_packets_o,
   output logic [15:0]                            last_latency_o,
   output logic [7:0]                             last_seq_o,
   output logic                                   err_o);

  import noc_perf_pkg::*;

  logic [15:0] cyc_r;
  logic [3:0]  pos_r;       // Flit position within the packet
  logic [7:0]  hdr_seq_r;   // Sequence number from the current header
  flit_u       word;
  logic        is_header;
  logic        is_final;
  logic        body_bad;

  assign link_ready_and_o = 1'b1;   // Always accepts

  assign word      = link_data_i;
  assign is_header = (pos_r == '0);
  assign is_final  = (pos_r == 4'(len_lp - 1));
  assign body_bad  = (word.body != body_word(hdr_seq_r, 8'(pos_r)));

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
      cyc_r <= '0;
    else
      cyc_r <= cyc_r + 16'd1;
  end

  // ********************
  // Framing and stats
  // ********************
  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      pos_r          <= '0;
      hdr_seq_r      <= '0;
      rx_packets_o   <= '0;
      last_latency_o <= '0;
      last_seq_o     <= '0;
      err_o          <= 1'b0;
    end
    else if (link_v_i)
    begin
      if (is_header)
      begin
        last_latency_o <= cyc_r - word.header.timestamp;   // Wraps mod 2^16
        last_seq_o     <= word.header.seq;
        hdr_seq_r      <= word.header.seq;
        if (word.header.len != 4'(len_lp))
          err_o <= 1'b1;
      end
      else if (body_bad)
        err_o <= 1'b1;

      if (is_final)
      begin
        pos_r        <= '0;
        rx_packets_o <= rx_packets_o + 16'd1;
      end
      else
        pos_r <= pos_r + 4'd1;
    end
  end

endmodule

`default_nettype wire

// File: src/noc_perf_pkg.sv
// Shared flit formats, widths and LFSR constants for the link traffic generator
// Imported by every stage that builds, stores or decodes flits
`default_nettype none

package noc_perf_pkg;

  // ********************
  // Widths and counts
  // ********************
  localparam int flit_width_lp     = 32;
  localparam int len_lp            = 4;   // Flits per packet, header included
  localparam int lg_queue_depth_lp = 3;
  localparam int pending_max_lp    = 15;  // Saturation of outstanding requests

  // ********************
  // LFSR
  // ********************
  localparam logic [15:0] lfsr_seed_lp = 16'hace1;
  localparam logic [15:0] lfsr_taps_lp = 16'hb400;  // Galois, right shifting

  // ********************
  // Flit formats
  // ********************

  // Header word, first flit of every packet
  typedef struct packed {
    logic [15:0] timestamp;
    logic [3:0]  node_id;
    logic [7:0]  seq;
    logic [3:0]  len;
  } flit_header_s;

  // Same link word seen as a header or as a raw body word
  typedef union packed {
    flit_header_s               header;
    logic [flit_width_lp-1:0]   body;
  } flit_u;

  // Body word layout: seq on top, flit index at the bottom, zeros between
  function automatic logic [flit_width_lp-1:0] body_word(
    input logic [7:0] seq,
    input logic [7:0] idx
  );
    logic [flit_width_lp-1:0] word;
    word        = '0;
    word[31:24] = seq;
    word[7:0]   = idx;
    return word;
  endfunction

endpackage

`default_nettype wire

// File: src/noc_perf_top.sv
// Link traffic generator and latency monitor
// Injection gate feeds the packet builder, whose flits queue for the outgoing link;
// the incoming link ends in the latency sink
`default_nettype none

module noc_perf_top
  #(parameter logic [3:0] node_id_p     = 4'd1,
    parameter int         utilization_p = 128)
  (input  logic                                   link_clk_i,
   input  logic                                   link_reset_i,
   input  logic                                   link_en_i,
   // Outgoing link
   output logic                                   link_v_o,
   output logic [noc_perf_pkg::flit_width_lp-1:0] link_data_o,
   input  logic                                   link_ready_and_i,
   // Incoming link
   input  logic                                   link_v_i,
   input  logic [noc_perf_pkg::flit_width_lp-1:0] link_data_i,
   output logic                                   link_ready_and_o,
   // Status
   output logic [15:0]                            rx_packets_o,
   output logic [15:0]                            last_latency_o,
   output logic [7:0]                             last_seq_o,
   output logic                                   err_o,
   output logic [3:0]                             pending_o,
   output logic [15:0]                            dropped_o);

  logic take;

  flit_stream_if build_q ();

  inject_gate #(.utilization_p(utilization_p)) inject_gate_i (
    .link_clk_i   (link_clk_i),
    .link_reset_i (link_reset_i),
    .link_en_i    (link_en_i),
    .take_i       (take),
    .pending_o    (pending_o),
    .dropped_o    (dropped_o)
  );

  packet_builder #(.node_id_p(node_id_p)) packet_builder_i (
    .link_clk_i   (link_clk_i),
    .link_reset_i (link_reset_i),
    .pending_i    (pending_o),
    .take_o       (take),
    .out          (build_q.source)
  );

  flit_queue flit_queue_i (
    .link_clk_i       (link_clk_i),
    .link_reset_i     (link_reset_i),
    .enq              (build_q.sink),
    .link_v_o         (link_v_o),
    .link_data_o      (link_data_o),
    .link_ready_and_i (link_ready_and_i)
  );

  latency_sink latency_sink_i (
    .link_clk_i       (link_clk_i),
    .link_reset_i     (link_reset_i),
    .link_v_i         (link_v_i),
    .link_data_i      (link_data_i),
    .link_ready_and_o (link_ready_and_o),
    .rx_packets_o     (rx_packets_o),
    .last_latency_o   (last_latency_o),
    .last_seq_o       (last_seq_o),
    .err_o            (err_o)
  );

endmodule

`default_nettype wire

// File: src/packet_builder.sv
// Turns pending requests into packets of len_lp flits on a flit stream
// Header carries the send timestamp, node id, sequence number and length
`default_nettype none

module packet_builder
  #(parameter logic [3:0] node_id_p = 4'd1)
  (input  logic        link_clk_i,
   input  logic        link_reset_i,
   input  logic [3:0]  pending_i,
   output logic        take_o,
   flit_stream_if.source out);

  import noc_perf_pkg::*;

  logic         sending_r; // Packet on offer
  logic [3:0]   idx_r;     // Position of the flit on offer
  logic [15:0]  ts_r;      // Free-running cycle count
  logic [15:0]  stamp_r;   // Timestamp of the packet in flight
  logic [7:0]   seq_r;
  logic         xfer;
  flit_header_s hdr;

  assign take_o = !sending_r && (pending_i != '0);
  assign xfer   = out.valid && out.ready;

  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
      ts_r <= '0;
    else
      ts_r <= ts_r + 16'd1;
  end

  // ********************
  // Packet FSM
  // ********************
  always_ff @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      sending_r <= 1'b0;
      idx_r     <= '0;
      seq_r     <= '0;
    end
    else if (take_o)
    begin
      sending_r <= 1'b1;
      idx_r     <= '0;
    end
    else if (xfer)
    begin
      if (out.last)
      begin
        sending_r <= 1'b0;
        seq_r     <= seq_r + 8'd1;
      end
      else
        idx_r <= idx_r + 4'd1;
    end
  end

  // Counter reads one higher when the header goes valid
  always_ff @(posedge link_clk_i)
  begin
    if (take_o)
      stamp_r <= ts_r + 16'd1;
  end

  assign hdr.timestamp = stamp_r;
  assign hdr.node_id   = node_id_p;
  assign hdr.seq       = seq_r;
  assign hdr.len       = 4'(len_lp);

  assign out.valid = sending_r;
  assign out.last  = (idx_r == 4'(len_lp - 1));
  always_comb
  begin
    if (idx_r == '0)
      out.data.header = hdr;
    else
      out.data.body = body_word(seq_r, 8'(idx_r));
  end

  // Offered flit holds until the queue takes it
  assert property (@(posedge link_clk_i) disable iff (link_reset_i)
    (out.valid && !out.ready) |=> (out.valid && $stable(out.data) && $stable(out.last)));

endmodule

`default_nettype wire

// File: test/tb_link_checker.sv
// Watches the DUT link ports and compares them with reference models of the
// injection LFSR, the flit format and the sink latency
// Instantiated once by the testbench top; reports errors as they happen
`default_nettype none

module tb_link_checker
  #(parameter logic [3:0] node_id_p     = 4'd1,
    parameter int         utilization_p = 128)
  (input  logic                                   link_clk_i,
   input  logic                                   link_reset_i,
   input  logic                                   link_en_i,
   input  logic                                   out_v_i,
   input  logic [noc_perf_pkg::flit_width_lp-1:0] out_data_i,
   input  logic                                   out_ready_i,
   input  logic                                   in_v_i,
   input  logic [noc_perf_pkg::flit_width_lp-1:0] in_data_i,
   input  logic                                   in_ready_i,
   input  logic [15:0]                            rx_packets_i,
   input  logic [15:0]                            last_latency_i,
   input  logic [7:0]                             last_seq_i,
   input  logic                                   err_i,
   input  logic [3:0]                             pending_i,
   input  logic [15:0]                            dropped_i,
   input  logic                                   tally_i,
   input  logic                                   expect_drops_i,
   output int                                     errors_o,
   output int                                     checks_o);

  import noc_perf_pkg::*;

  int          errors = 0;
  int          checks = 0;
  int          hits;
  int          sent;
  int          out_pos;
  int          in_pos;
  logic        rst_seen = 1'b0;
  logic        err_seen;
  logic        lat_due;
  logic [15:0] lfsr;
  logic [15:0] cyc;         // Runs in step with the sink's own counter
  logic [15:0] lat_exp;
  logic [15:0] drops_prev;
  logic [7:0]  out_seq;     // Next sequence number expected on the link
  logic [7:0]  cur_seq;
  logic [7:0]  in_seq;
  logic [7:0]  lat_seq;
  flit_u       out_word;
  flit_u       in_word;

  assign out_word = out_data_i;
  assign in_word  = in_data_i;
  assign errors_o = errors;
  assign checks_o = checks;

  // Galois LFSR, right shifting
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hb400;
    return s >> 1;
  endfunction

  // Body word: seq on top, index at the bottom
  function automatic logic [31:0] body_model(input logic [7:0] seq, input int idx);
    return {seq, 16'h0000, 8'(idx)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      $display("FAILED %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  always @(posedge link_clk_i)
  begin
    if (link_reset_i)
    begin
      if (rst_seen)
      begin
        check_value("link_v_o", 32'(out_v_i), 32'd0);
        check_value("err_o", 32'(err_i), 32'd0);
        check_value("link_ready_and_o", 32'(in_ready_i), 32'd1);
        check_value("pending_o", 32'(pending_i), 32'd0);
      end
      rst_seen   = 1'b1;
      err_seen   = 1'b0;
      lat_due    = 1'b0;
      lfsr       = 16'hace1;
      cyc        = '0;
      hits       = 0;
      sent       = 0;
      out_pos    = 0;
      in_pos     = 0;
      out_seq    = '0;
      in_seq     = '0;
      drops_prev = '0;
    end
    else
    begin
      // ********************
      // Sink outputs, one cycle after a header
      // ********************
      if (lat_due)
      begin
        check_value("last_latency_o", 32'(last_latency_i), 32'(lat_exp));
        check_value("last_seq_o", 32'(last_seq_i), 32'(lat_seq));
        lat_due = 1'b0;
      end
      if (err_i && !err_seen)
      begin
        $display("Sink raised its framing error flag");
        errors++;
        err_seen = 1'b1;
      end

      if (link_en_i)
      begin
        lfsr = lfsr_step(lfsr);
        if (int'(lfsr[7:0]) < utilization_p)
          hits++;
      end

      // ********************
      // Outgoing framing
      // ********************
      if (out_v_i && out_ready_i)
      begin
        if (out_pos == 0)
        begin
          check_value("link_data_o.node_id", 32'(out_word.header.node_id), 32'(node_id_p));
          check_value("link_data_o.len", 32'(out_word.header.len), 32'(len_lp));
          check_value("link_data_o.seq", 32'(out_word.header.seq), 32'(out_seq));
          cur_seq = out_seq;
          out_seq = out_seq + 8'd1;
          sent++;
        end
        else
          check_value("link_data_o", out_word.body, body_model(cur_seq, out_pos));
        out_pos = (out_pos == len_lp - 1) ? 0 : out_pos + 1;
      end

      // Incoming header sets up the latency compare
      if (in_v_i && in_ready_i)
      begin
        if (in_pos == 0)
        begin
          check_value("link_data_i.seq", 32'(in_word.header.seq), 32'(in_seq));
          lat_exp = cyc - in_word.header.timestamp;
          lat_seq = in_seq;
          lat_due = 1'b1;
          in_seq  = in_seq + 8'd1;
        end
        in_pos = (in_pos == len_lp - 1) ? 0 : in_pos + 1;
      end

      if (tally_i)
      begin
        check_value("dropped_o", 32'(dropped_i), 32'(hits - sent));
        check_value("rx_packets_o", 32'(rx_packets_i), 32'(sent));
        if (expect_drops_i && (dropped_i == drops_prev))
        begin
          $display("Back-pressure stretch dropped no requests");
          errors++;
        end
        drops_prev = dropped_i;
      end

      cyc = cyc + 16'd1;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_noc_perf.sv
// Testbench top for the link traffic generator: clock, reset, loopback link
// with random ready on the outgoing side, test sequence and timeout
`default_nettype none

module tb_noc_perf;

  localparam logic [3:0] node_id_lp     = 4'd5;
  localparam int         utilization_lp = 24;
  localparam int         window_lp      = 400;  // Enabled cycles, injection test
  localparam int         stall_lp       = 400;  // Ready held low
  localparam int         drain_lp       = 300;  // Worst case drain of a full pipe
  localparam int         test_len_lp    = 3 + window_lp + stall_lp + window_lp / 4
                                          + 2 * drain_lp;
  localparam int         limit_lp       = 4 * test_len_lp;

  logic        link_clk;
  logic        link_reset;
  logic        link_en;
  logic        link_ready_and;
  logic        link_v;
  logic [31:0] link_data;
  logic        lb_v = 1'b0;  // Loopback register
  logic [31:0] lb_data = '0;
  logic        rx_ready;
  logic [15:0] rx_packets;
  logic [15:0] last_latency;
  logic [7:0]  last_seq;
  logic        err;
  logic [3:0]  pending;
  logic [15:0] dropped;
  logic        tally;
  logic        expect_drops;
  logic        random_ready;
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          failed_tests;
  int          errors_before;
  int          cycles = 0;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    link_clk = 1'b0;
    forever #2 link_clk = ~link_clk;
  end

  noc_perf_top #(.node_id_p(node_id_lp), .utilization_p(utilization_lp)) noc_perf_top_i (
    .link_clk_i       (link_clk),
    .link_reset_i     (link_reset),
    .link_en_i        (link_en),
    .link_v_o         (link_v),
    .link_data_o      (link_data),
    .link_ready_and_i (link_ready_and),
    .link_v_i         (lb_v),
    .link_data_i      (lb_data),
    .link_ready_and_o (rx_ready),
    .rx_packets_o     (rx_packets),
    .last_latency_o   (last_latency),
    .last_seq_o       (last_seq),
    .err_o            (err),
    .pending_o        (pending),
    .dropped_o        (dropped)
  );

  tb_link_checker #(.node_id_p(node_id_lp), .utilization_p(utilization_lp)) checker_i (
    .link_clk_i     (link_clk),
    .link_reset_i   (link_reset),
    .link_en_i      (link_en),
    .out_v_i        (link_v),
    .out_data_i     (link_data),
    .out_ready_i    (link_ready_and),
    .in_v_i         (lb_v),
    .in_data_i      (lb_data),
    .in_ready_i     (rx_ready),
    .rx_packets_i   (rx_packets),
    .last_latency_i (last_latency),
    .last_seq_i     (last_seq),
    .err_i          (err),
    .pending_i      (pending),
    .dropped_i      (dropped),
    .tally_i        (tally),
    .expect_drops_i (expect_drops),
    .errors_o       (errors),
    .checks_o       (checks)
  );

  always @(posedge link_clk)
  begin
    if (link_reset)
    begin
      lb_v    <= 1'b0;
      lb_data <= '0;
    end
    else
    begin
      lb_v    <= link_v && link_ready_and;
      lb_data <= link_data;
    end
  end

  // Ready of the outgoing link, random or held low
  initial
  begin
    link_ready_and = 1'b0;
    lcg_state      = 32'he600_aa18;
    forever
    begin
      @(negedge link_clk);
      if (random_ready)
      begin
        lcg_state      = lcg_next(lcg_state);
        link_ready_and = (lcg_state[31:30] != 2'b00);
      end
      else
        link_ready_and = 1'b0;
    end
  end

  always @(posedge link_clk)
  begin
    cycles++;
    if (cycles > limit_lp)
    begin
      $display("Timeout: the link did not drain within %0d cycles", limit_lp);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic finish_test(input string name);
    if (errors == errors_before)
      $display("Test %s: ok", name);
    else
    begin
      failed_tests++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // Waits for a quiet pipe, then asks the checker to compare totals
  task automatic drain_and_tally(input logic drops_wanted);
    int quiet;
    quiet = 0;
    while (quiet < 8)
    begin
      @(negedge link_clk);
      if ((pending == '0) && !link_v && !lb_v)
        quiet++;
      else
        quiet = 0;
    end
    expect_drops = drops_wanted;
    tally        = 1'b1;
    @(negedge link_clk);
    tally        = 1'b0;
  endtask

  initial
  begin
    link_reset    = 1'b1;
    link_en       = 1'b0;
    tally         = 1'b0;
    expect_drops  = 1'b0;
    random_ready  = 1'b0;
    failed_tests  = 0;
    errors_before = 0;
    repeat (2) @(negedge link_clk);
    link_reset = 1'b0;
    finish_test("reset");

    random_ready <= 1'b1;
    @(negedge link_clk);
    link_en = 1'b1;
    repeat (window_lp) @(negedge link_clk);
    link_en = 1'b0;
    drain_and_tally(1'b0);
    finish_test("injection count, framing and latency");

    // ********************
    // Back-pressure
    // ********************
    random_ready <= 1'b0;
    link_en = 1'b1;
    repeat (stall_lp) @(negedge link_clk);
    random_ready <= 1'b1;
    repeat (window_lp / 4) @(negedge link_clk);
    link_en = 1'b0;
    drain_and_tally(1'b1);
    finish_test("back-pressure");

    $display("Tests run 3, failed %0d; checks %0d, errors %0d", failed_tests, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
